//--- common/jt900h_regmap_pkg.sv
package jt900h_regmap_pkg;

    // operand width
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_WORD = 2'd1,
        SZ_QUAD = 2'd2
    } size_t;

    // base addresses of the windows in long format
    localparam logic [7:0] PREVBANK = 8'hd0;
    localparam logic [7:0] CURBANK  = 8'he0;
    localparam logic [7:0] FIXREGS  = 8'hf0;   // IX, IY, IZ, SP

    typedef struct packed {
        logic       sln;    // low here
        logic [7:0] addr;   // long address
    } sel_long_t;

    typedef struct packed {
        logic       sln;    // high here
        logic [4:0] pad;
        logic [2:0] code;   // short register code
    } sel_short_t;

    // source selector, sln picks the view
    typedef union packed {
        sel_long_t  lform;
        sel_short_t sform;
    } reg_sel_u;

    // Short codes always refer to the current bank. Word and quad codes
    // 4..7 land past the banked window, in the fixed group at 0xF0.
    function automatic logic [7:0] short_to_long(input logic [2:0] code, input size_t size);
        logic [7:0] offset;
        if (size == SZ_BYTE) begin
            case (code)
                3'd0:    offset = 8'd1;    // W
                3'd1:    offset = 8'd0;    // A
                3'd2:    offset = 8'd5;    // B
                3'd3:    offset = 8'd4;    // C
                3'd4:    offset = 8'd9;    // D
                3'd5:    offset = 8'd8;    // E
                3'd6:    offset = 8'd13;   // H
                default: offset = 8'd12;   // L
            endcase
        end else begin
            offset = {3'd0, code, 2'd0};   // WA BC DE HL IX IY IZ SP
        end
        return CURBANK + offset;
    endfunction

endpackage

//--- common/jt900h_exec_pkg.sv
package jt900h_exec_pkg;

    import jt900h_regmap_pkg::*;

    typedef enum logic [3:0] {
        OP_LD_IMM = 4'd0,
        OP_LD_REG = 4'd1,
        OP_ADD    = 4'd2,
        OP_SUB    = 4'd3,
        OP_AND    = 4'd4,
        OP_OR     = 4'd5,
        OP_XOR    = 4'd6,
        OP_INCF   = 4'd7,   // current bank + 1
        OP_DECF   = 4'd8,   // current bank - 1
        OP_LDF    = 4'd9    // bank from imm[1:0]
    } op_t;

    typedef struct packed {
        op_t         op;
        size_t       size;
        reg_sel_u    src;
        logic [2:0]  dst;    // short code, current bank
        logic [31:0] imm;
    } cmd_t;

    typedef struct packed {
        logic zero;
        logic sign;
        logic carry;
    } flags_t;

    // write-back bundle to the register file
    typedef struct packed {
        logic        we;
        logic [2:0]  dst;
        size_t       size;
        logic [31:0] data;
    } wb_t;

    typedef enum logic [1:0] {
        BANK_NONE = 2'd0,
        BANK_INC  = 2'd1,
        BANK_DEC  = 2'd2,
        BANK_SET  = 2'd3
    } bank_op_t;

endpackage

//--- regs/jt900h_regs.sv
`timescale 1ns/100ps

module jt900h_regs
    import jt900h_regmap_pkg::*, jt900h_exec_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cen,

    input  size_t       size,       // read width
    input  reg_sel_u    src_sel,
    input  logic [2:0]  dst,
    output logic [31:0] src_out,
    output logic [31:0] dst_out,

    input  wb_t         wb,
    input  bank_op_t    bank_op,
    input  logic [1:0]  bank_val
);

// entries 0..15 are WA..HL of banks 0..3, 16..19 are IX..SP
logic [3:0][7:0] rf [0:19];

logic [1:0] cur_bank;
logic [1:0] prev_bank;
logic [1:0] next_bank;

logic [7:0] src_long;
logic [7:0] dst_long;
logic [7:0] wr_long;
logic [4:0] src_idx;
logic [4:0] dst_idx;
logic [4:0] wr_idx;

function automatic logic [4:0] long_to_idx(
    input logic [7:0] addr,
    input logic [1:0] cur,
    input logic [1:0] prev
);
    logic [4:0] idx;
    idx = 5'd0;
    if (addr[7:6] == 2'b00)
        idx = {1'b0, addr[5:2]};            // absolute banks
    else if (addr[7:4] == PREVBANK[7:4])
        idx = {1'b0, prev, addr[3:2]};
    else if (addr[7:4] == CURBANK[7:4])
        idx = {1'b0, cur, addr[3:2]};
    else if (addr[7:4] == FIXREGS[7:4])
        idx = {3'b100, addr[3:2]};          // shared by all banks
    return idx;
endfunction

// byte and word picked by the low address bits, then zero-extended
function automatic logic [31:0] read_lanes(
    input logic [3:0][7:0] entry,
    input logic [1:0]      sub,
    input size_t           sz
);
    logic [15:0] half;
    half = sub[1] ? entry[3:2] : entry[1:0];
    case (sz)
        SZ_BYTE: return {24'd0, entry[sub]};
        SZ_WORD: return {16'd0, half};
        default: return entry;
    endcase
endfunction

always_comb begin
    src_long = src_sel.sform.sln ? short_to_long(src_sel.sform.code, size)
                                 : src_sel.lform.addr;
    dst_long = short_to_long(dst, size);
    wr_long  = short_to_long(wb.dst, wb.size);
    src_idx  = long_to_idx(src_long, cur_bank, prev_bank);
    dst_idx  = long_to_idx(dst_long, cur_bank, prev_bank);
    wr_idx   = long_to_idx(wr_long, cur_bank, prev_bank);
end

always_ff @(posedge clk) begin
    if (cen) begin
        src_out <= read_lanes(rf[src_idx], src_long[1:0], size);
        dst_out <= read_lanes(rf[dst_idx], dst_long[1:0], size);
    end
end

always_ff @(posedge clk) begin
    if (cen && wb.we) begin
        case (wb.size)
            SZ_BYTE: rf[wr_idx][{1'b0, wr_long[0]}] <= wb.data[7:0];   // lane 0 or 1
            SZ_WORD: rf[wr_idx][1:0] <= wb.data[15:0];
            default: rf[wr_idx] <= wb.data;
        endcase
    end
end

always_comb begin
    case (bank_op)
        BANK_INC: next_bank = cur_bank + 2'd1;
        BANK_DEC: next_bank = cur_bank - 2'd1;
        BANK_SET: next_bank = bank_val;
        default:  next_bank = cur_bank;
    endcase
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        cur_bank  <= 2'd0;
        prev_bank <= 2'd0;
    end else if (cen && next_bank != cur_bank) begin
        prev_bank <= cur_bank;   // previous bank follows every change
        cur_bank  <= next_bank;
    end
end

endmodule

//--- source/jt900h_cen.sv
`timescale 1ns/100ps

module jt900h_cen #(
    parameter int CEN_DIV = 2
) (
    input  logic clk,
    input  logic rst_n,
    output logic cen
);

localparam int CW = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;

logic [CW-1:0] cnt;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        cnt <= '0;
        cen <= 1'b0;
    end else if (cnt == CW'(CEN_DIV - 1)) begin
        cnt <= '0;
        cen <= 1'b1;   // one clock per wrap
    end else begin
        cnt <= cnt + 1'b1;
        cen <= 1'b0;
    end
end

endmodule

//--- source/jt900h_alu.sv
`timescale 1ns/100ps

module jt900h_alu
    import jt900h_regmap_pkg::*, jt900h_exec_pkg::*;
(
    input  op_t         op,
    input  size_t       size,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] y,
    output flags_t      flags
);

logic [31:0] mask;
logic [31:0] am;
logic [31:0] bm;
logic [32:0] full;   // one bit above quad for the carry

always_comb begin
    case (size)
        SZ_BYTE: mask = 32'h0000_00ff;
        SZ_WORD: mask = 32'h0000_ffff;
        default: mask = 32'hffff_ffff;
    endcase
end

assign am = a & mask;
assign bm = b & mask;

always_comb begin
    case (op)
        OP_ADD:  full = {1'b0, am} + {1'b0, bm};
        OP_SUB:  full = {1'b0, am} - {1'b0, bm};   // borrow sets bit at width
        OP_AND:  full = {1'b0, am & bm};
        OP_OR:   full = {1'b0, am | bm};
        OP_XOR:  full = {1'b0, am ^ bm};
        default: full = {1'b0, bm};                // loads pass b
    endcase
end

assign y = full[31:0] & mask;

always_comb begin
    flags.zero = (y == 32'd0);
    case (size)
        SZ_BYTE: begin
            flags.sign  = y[7];
            flags.carry = full[8];
        end
        SZ_WORD: begin
            flags.sign  = y[15];
            flags.carry = full[16];
        end
        default: begin
            flags.sign  = y[31];
            flags.carry = full[32];
        end
    endcase
    if (op != OP_ADD && op != OP_SUB)
        flags.carry = 1'b0;
end

endmodule

//--- source/jt900h_seq.sv
`timescale 1ns/100ps

module jt900h_seq
    import jt900h_regmap_pkg::*, jt900h_exec_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cen,

    input  logic        cmd_valid,
    input  cmd_t        cmd,
    output logic        busy,
    output logic        done,

    // register file side
    output reg_sel_u    src_sel,
    output logic [2:0]  dst,
    output size_t       size,
    input  logic [31:0] src_val,
    input  logic [31:0] dst_val,

    // ALU side
    output op_t         alu_op,
    output logic [31:0] alu_a,
    output logic [31:0] alu_b,
    input  logic [31:0] alu_y,
    input  flags_t      alu_flags,

    output wb_t         wb,
    output bank_op_t    bank_op,
    output logic [1:0]  bank_val,
    output logic [31:0] result,
    output flags_t      flags
);

typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_EXEC,
    S_WRITE
} state_t;

state_t state;
cmd_t   cmd_q;
logic   bank_cmd;

assign bank_cmd = cmd_q.op inside {OP_INCF, OP_DECF, OP_LDF};
assign busy     = (state != S_IDLE);
assign done     = (state == S_WRITE) && cen;   // third cen pulse

assign src_sel  = cmd_q.src;
assign dst      = cmd_q.dst;
assign size     = cmd_q.size;
assign alu_op   = cmd_q.op;
assign bank_val = cmd_q.imm[1:0];

// acceptance needs no cen, the steps after it do
always_ff @(posedge clk) begin
    if (!rst_n) begin
        state <= S_IDLE;
    end else begin
        case (state)
            S_IDLE:  if (cmd_valid) state <= S_READ;
            S_READ:  if (cen) state <= S_EXEC;
            S_EXEC:  if (cen) state <= S_WRITE;
            default: if (cen) state <= S_IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state == S_IDLE && cmd_valid)
        cmd_q <= cmd;
end

// operand choice, src_val and dst_val hold the READ sample here
always_ff @(posedge clk) begin
    if (state == S_EXEC && cen) begin
        case (cmd_q.op)
            OP_LD_REG: begin
                alu_a <= 32'd0;
                alu_b <= src_val;
            end
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                alu_a <= dst_val;
                alu_b <= src_val;
            end
            default: begin   // ld_imm and bank ops
                alu_a <= 32'd0;
                alu_b <= cmd_q.imm;
            end
        endcase
    end
end

always_comb begin
    wb.we   = (state == S_WRITE) && !bank_cmd;
    wb.dst  = cmd_q.dst;
    wb.size = cmd_q.size;
    wb.data = alu_y;
end

always_comb begin
    bank_op = BANK_NONE;
    if (state == S_WRITE) begin
        case (cmd_q.op)
            OP_INCF: bank_op = BANK_INC;
            OP_DECF: bank_op = BANK_DEC;
            OP_LDF:  bank_op = BANK_SET;
            default: bank_op = BANK_NONE;
        endcase
    end
end

// bank switches leave the last written value in place
always_ff @(posedge clk) begin
    if (!rst_n) begin
        result <= 32'd0;
        flags  <= '0;
    end else if (done && !bank_cmd) begin
        result <= alu_y;
        flags  <= alu_flags;
    end
end

endmodule

//--- source/jt900h_exec.sv
`timescale 1ns/100ps

module jt900h_exec
    import jt900h_regmap_pkg::*, jt900h_exec_pkg::*;
#(
    parameter int CEN_DIV = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cmd_valid,
    input  cmd_t        cmd,
    output logic        busy,
    output logic        done,
    output logic [31:0] result,
    output flags_t      flags
);

logic        cen;
reg_sel_u    src_sel;
logic [2:0]  dst;
size_t       size;
logic [31:0] src_val;
logic [31:0] dst_val;
op_t         alu_op;
logic [31:0] alu_a;
logic [31:0] alu_b;
logic [31:0] alu_y;
flags_t      alu_flags;
wb_t         wb;
bank_op_t    bank_op;
logic [1:0]  bank_val;

jt900h_cen #(.CEN_DIV(CEN_DIV)) u_cen (
    .clk   (clk),
    .rst_n (rst_n),
    .cen   (cen)
);

jt900h_seq u_seq (
    .clk       (clk),       .rst_n     (rst_n),    .cen      (cen),
    .cmd_valid (cmd_valid), .cmd       (cmd),      .busy     (busy),
    .done      (done),      .src_sel   (src_sel),  .dst      (dst),
    .size      (size),      .src_val   (src_val),  .dst_val  (dst_val),
    .alu_op    (alu_op),    .alu_a     (alu_a),    .alu_b    (alu_b),
    .alu_y     (alu_y),     .alu_flags (alu_flags), .wb      (wb),
    .bank_op   (bank_op),   .bank_val  (bank_val), .result   (result),
    .flags     (flags)
);

jt900h_alu u_alu (
    .op    (alu_op),
    .size  (size),
    .a     (alu_a),
    .b     (alu_b),
    .y     (alu_y),
    .flags (alu_flags)
);

jt900h_regs u_regs (
    .clk      (clk),      .rst_n    (rst_n),    .cen     (cen),
    .size     (size),     .src_sel  (src_sel),  .dst     (dst),
    .src_out  (src_val),  .dst_out  (dst_val),  .wb      (wb),
    .bank_op  (bank_op),  .bank_val (bank_val)
);

endmodule

//--- sim/jt900h_exec_sva.sv
`timescale 1ns/100ps

module jt900h_exec_sva
    import jt900h_exec_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        busy,
    input logic        done,
    input logic [31:0] result,
    input flags_t      flags,
    input logic        chk_en,      // high when result and flags are predicted
    input logic [31:0] exp_result,
    input flags_t      exp_flags
);

int fail_cnt = 0;   // read back by the testbench

reset_state: assert property (@(posedge clk)
    !rst_n |=> !busy && !done && result == 32'd0 && flags == 3'b000)
    else begin
        $error("FAILED %0t: busy, done, result or flags not cleared by reset", $time);
        fail_cnt++;
    end

done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else begin
        $error("FAILED %0t: done stayed high for more than one clock", $time);
        fail_cnt++;
    end

// busy drops on the clock after done
busy_release: assert property (@(posedge clk) disable iff (!rst_n) done |=> !busy)
    else begin
        $error("FAILED %0t: busy still high the clock after done", $time);
        fail_cnt++;
    end

// result and flags register on the done clock
result_check: assert property (@(posedge clk) disable iff (!rst_n)
    done && chk_en |=> result == exp_result)
    else begin
        $error("FAILED %0t: result %h, expected %h", $time, $sampled(result), exp_result);
        fail_cnt++;
    end

flags_check: assert property (@(posedge clk) disable iff (!rst_n)
    done && chk_en |=> flags == exp_flags)
    else begin
        $error("FAILED %0t: flags %b, expected %b", $time, $sampled(flags), exp_flags);
        fail_cnt++;
    end

// bank switches keep the last written value
bank_hold: assert property (@(posedge clk) disable iff (!rst_n)
    done && !chk_en |=> $stable(result) && $stable(flags))
    else begin
        $error("FAILED %0t: result or flags changed on a bank switch", $time);
        fail_cnt++;
    end

endmodule

//--- sim/jt900h_exec_tb.sv
`timescale 1ns/100ps

module jt900h_exec_tb
    import jt900h_regmap_pkg::*, jt900h_exec_pkg::*;
();

localparam int CEN_DIV = 2;
localparam int TIMEOUT = 50;   // clocks allowed per command

logic        clk;
logic        rst_n;
logic        cmd_valid;
cmd_t        cmd;
logic        busy;
logic        done;
logic [31:0] result;
flags_t      flags;

// expected values, read by the bound checker
logic        chk_en;
logic [31:0] exp_result;
flags_t      exp_flags;

logic [31:0] model [0:19];   // WA..HL of banks 0..3, then IX..SP
logic [1:0]  cur_m;
logic [1:0]  prev_m;
logic        timed_out;
int          n_tests;
int          n_bad;
int          seen_errs;

jt900h_exec #(.CEN_DIV(CEN_DIV)) dut (
    .clk       (clk),       .rst_n  (rst_n),  .cmd_valid (cmd_valid),
    .cmd       (cmd),       .busy   (busy),   .done      (done),
    .result    (result),    .flags  (flags)
);

bind jt900h_exec jt900h_exec_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .busy       (busy),
    .done       (done),
    .result     (result),
    .flags      (flags),
    .chk_en     (jt900h_exec_tb.chk_en),
    .exp_result (jt900h_exec_tb.exp_result),
    .exp_flags  (jt900h_exec_tb.exp_flags)
);

always #10 clk = ~clk;

// byte codes pair up as W/A, B/C, D/E, H/L
function automatic int reg_idx(input logic [2:0] code, input size_t sz);
    if (sz == SZ_BYTE)
        return int'(cur_m) * 4 + int'(code) / 2;
    else if (code < 3'd4)
        return int'(cur_m) * 4 + int'(code);
    else
        return 12 + int'(code);   // IX..SP
endfunction

function automatic logic [31:0] read_short(input logic [2:0] code, input size_t sz);
    logic [31:0] v;
    v = model[reg_idx(code, sz)];
    case (sz)
        SZ_BYTE: return code[0] ? {24'd0, v[7:0]} : {24'd0, v[15:8]};
        SZ_WORD: return {16'd0, v[15:0]};
        default: return v;
    endcase
endfunction

// quad reads through the long windows
function automatic logic [31:0] read_long(input logic [7:0] addr);
    case (addr[7:4])
        4'hd:    return model[int'(prev_m) * 4 + int'(addr[3:2])];
        4'he:    return model[int'(cur_m) * 4 + int'(addr[3:2])];
        default: return model[16 + int'(addr[3:2])];
    endcase
endfunction

task automatic write_short(input logic [2:0] code, input size_t sz, input logic [31:0] val);
    int i;
    i = reg_idx(code, sz);
    if (sz == SZ_QUAD)
        model[i] = val;
    else if (sz == SZ_WORD)
        model[i][15:0] = val[15:0];
    else if (code[0])
        model[i][7:0] = val[7:0];     // A, C, E, L
    else
        model[i][15:8] = val[7:0];    // W, B, D, H
endtask

task automatic alu_expect(input op_t op, input size_t sz, input logic [31:0] a,
                          input logic [31:0] b);
    logic [31:0] mask;
    logic [31:0] am;
    logic [31:0] bm;
    mask = (sz == SZ_BYTE) ? 32'h0000_00ff : (sz == SZ_WORD) ? 32'h0000_ffff : 32'hffff_ffff;
    am = a & mask;
    bm = b & mask;
    exp_flags.carry = 1'b0;
    case (op)
        OP_ADD: begin
            exp_result      = (am + bm) & mask;
            exp_flags.carry = exp_result < am;   // wrapped past the width
        end
        OP_SUB: begin
            exp_result      = (am - bm) & mask;
            exp_flags.carry = am < bm;           // borrow
        end
        OP_AND:  exp_result = am & bm;
        OP_OR:   exp_result = am | bm;
        OP_XOR:  exp_result = am ^ bm;
        default: exp_result = bm;                // loads
    endcase
    exp_flags.zero = (exp_result == 32'd0);
    exp_flags.sign = |(exp_result & mask & ~(mask >> 1));
endtask

task automatic predict(input cmd_t c);
    logic [31:0] a;
    logic [31:0] b;
    logic [1:0]  nb;
    a = read_short(c.dst, c.size);
    if (c.src.sform.sln)
        b = read_short(c.src.sform.code, c.size);
    else
        b = read_long(c.src.lform.addr);
    chk_en = 1'b1;
    case (c.op)
        OP_INCF, OP_DECF, OP_LDF: begin
            chk_en = 1'b0;
            nb = (c.op == OP_INCF) ? cur_m + 2'd1 :
                 (c.op == OP_DECF) ? cur_m - 2'd1 : c.imm[1:0];
            if (nb != cur_m) begin
                prev_m = cur_m;
                cur_m  = nb;
            end
        end
        OP_LD_IMM: alu_expect(c.op, c.size, 32'd0, c.imm);
        default:   alu_expect(c.op, c.size, a, b);
    endcase
    if (chk_en)
        write_short(c.dst, c.size, exp_result);
endtask

function automatic cmd_t make_cmd(input op_t op, input size_t sz, input logic sln,
                                  input logic [7:0] src, input logic [2:0] dst,
                                  input logic [31:0] imm);
    cmd_t c;
    c.op   = op;
    c.size = sz;
    c.dst  = dst;
    c.imm  = imm;
    if (sln) begin
        c.src.sform.sln  = 1'b1;
        c.src.sform.pad  = 5'd0;
        c.src.sform.code = src[2:0];
    end else begin
        c.src.lform.sln  = 1'b0;
        c.src.lform.addr = src;
    end
    return c;
endfunction

task automatic issue(input cmd_t c);
    cmd       = c;
    cmd_valid = 1'b1;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
endtask

task automatic wait_done();
    int cnt;
    cnt = 0;
    while (!done && cnt < TIMEOUT) begin
        @(posedge clk);
        #1;
        cnt++;
    end
    if (!done) begin
        timed_out = 1'b1;
        $display("timeout: no done pulse within %0d clocks at %0t", TIMEOUT, $time);
    end else begin
        @(posedge clk);   // result registers here
        #1;
        @(posedge clk);   // checker samples it here
        #1;
    end
endtask

task automatic run(input cmd_t c);
    if (!timed_out) begin
        predict(c);
        issue(c);
        wait_done();
    end
endtask

task automatic report(input string name);
    int errs;
    errs = dut.u_sva.fail_cnt;
    if (!timed_out) begin
        n_tests++;
        if (errs != seen_errs) begin
            n_bad++;
            $display("FAILED %0t: %s, %0d assertion failure(s)", $time, name, errs - seen_errs);
        end else begin
            $display("%s: passed", name);
        end
    end
    seen_errs = errs;
endtask

initial begin
    size_t       sz;
    op_t         op;
    cmd_t        c;
    logic [31:0] v;
    void'($urandom(32'h2be0));
    clk        = 1'b0;
    rst_n      = 1'b0;
    cmd_valid  = 1'b0;
    cmd        = '0;
    chk_en     = 1'b0;
    exp_result = 32'd0;
    exp_flags  = '0;
    cur_m      = 2'd0;
    prev_m     = 2'd0;
    timed_out  = 1'b0;
    n_tests    = 0;
    n_bad      = 0;
    seen_errs  = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // W and A bytes compose into WA
    run(make_cmd(OP_LD_IMM, SZ_QUAD, 1'b1, 8'd0, 3'd0, 32'd0));
    run(make_cmd(OP_LD_IMM, SZ_BYTE, 1'b1, 8'd0, 3'd0, $urandom));
    run(make_cmd(OP_LD_IMM, SZ_BYTE, 1'b1, 8'd0, 3'd1, $urandom));
    run(make_cmd(OP_LD_REG, SZ_QUAD, 1'b0, CURBANK, 3'd7, 32'd0));
    report("byte lanes");

    for (int s = 0; s < 3; s++) begin
        sz = size_t'(s);
        for (int k = 0; k < 2; k++) begin
            run(make_cmd(OP_LD_IMM, sz, 1'b1, 8'd0, 3'd3, $urandom));
            run(make_cmd(OP_LD_IMM, sz, 1'b1, 8'd0, 3'd2, $urandom));
            run(make_cmd(k ? OP_SUB : OP_ADD, sz, 1'b1, 8'd2, 3'd3, 32'd0));
        end
        run(make_cmd(OP_SUB, sz, 1'b1, 8'd3, 3'd3, 32'd0));   // zero result
    end
    report("arithmetic");

    for (int k = 0; k < 9; k++) begin
        op = op_t'(int'(OP_AND) + k % 3);
        sz = size_t'(k / 3);
        run(make_cmd(OP_LD_IMM, sz, 1'b1, 8'd0, 3'd1, $urandom));
        run(make_cmd(OP_LD_IMM, sz, 1'b1, 8'd0, 3'd0, $urandom));
        run(make_cmd(op, sz, 1'b1, 8'd0, 3'd1, 32'd0));
    end
    report("logic");

    run(make_cmd(OP_LDF, SZ_QUAD, 1'b1, 8'd0, 3'd0, 32'd0));
    run(make_cmd(OP_LD_IMM, SZ_QUAD, 1'b1, 8'd0, 3'd1, $urandom));
    run(make_cmd(OP_INCF, SZ_QUAD, 1'b1, 8'd0, 3'd0, 32'd0));
    run(make_cmd(OP_LD_IMM, SZ_QUAD, 1'b1, 8'd0, 3'd1, $urandom));
    run(make_cmd(OP_LD_REG, SZ_QUAD, 1'b0, PREVBANK + 8'd4, 3'd7, 32'd0));
    run(make_cmd(OP_LD_REG, SZ_QUAD, 1'b0, CURBANK + 8'd4, 3'd7, 32'd0));
    report("bank isolation");

    // IX lives outside the banks
    run(make_cmd(OP_LD_IMM, SZ_QUAD, 1'b1, 8'd0, 3'd4, $urandom));
    run(make_cmd(OP_LDF, SZ_QUAD, 1'b1, 8'd0, 3'd0, 32'd2));
    run(make_cmd(OP_LD_REG, SZ_QUAD, 1'b1, 8'd4, 3'd3, 32'd0));
    run(make_cmd(OP_DECF, SZ_QUAD, 1'b1, 8'd0, 3'd0, 32'd0));
    run(make_cmd(OP_LD_REG, SZ_QUAD, 1'b1, 8'd4, 3'd3, 32'd0));
    report("fixed registers");

    // second strobe lands while the first command is in flight
    v = $urandom;
    c = make_cmd(OP_LD_IMM, SZ_QUAD, 1'b1, 8'd0, 3'd2, v);
    if (!timed_out) begin
        predict(c);
        issue(c);
        issue(make_cmd(OP_LD_IMM, SZ_QUAD, 1'b1, 8'd0, 3'd2, ~v));
        wait_done();
    end
    run(make_cmd(OP_LD_REG, SZ_QUAD, 1'b1, 8'd2, 3'd3, 32'd0));
    report("busy strobe");

    $display("%0d tests, %0d failed, %0d assertion failures",
             n_tests, n_bad, dut.u_sva.fail_cnt);
    if (timed_out || n_bad != 0 || dut.u_sva.fail_cnt != 0) begin
        $display("Test FAILED");
    end else begin
        $display("Test OK");
    end
    $finish;
end

endmodule

//--- project.f
common/jt900h_regmap_pkg.sv
common/jt900h_exec_pkg.sv
regs/jt900h_regs.sv
source/jt900h_cen.sv
source/jt900h_alu.sv
source/jt900h_seq.sv
source/jt900h_exec.sv
sim/jt900h_exec_sva.sv
sim/jt900h_exec_tb.sv

//--- Bender.yml
package:
  name: jt900h_exec

sources:
  # packages before the modules that import them
  - common/jt900h_regmap_pkg.sv
  - common/jt900h_exec_pkg.sv
  - regs/jt900h_regs.sv
  - source/jt900h_cen.sv
  - source/jt900h_alu.sv
  - source/jt900h_seq.sv
  - source/jt900h_exec.sv
  - target: simulation
    files:
      - sim/jt900h_exec_sva.sv
      - sim/jt900h_exec_tb.sv
